/* mini_vec.f */
design/vec_pkg.sv
design/vec_dispatcher.sv
design/vec_insn_queue.sv
design/vec_lane.sv
design/vec_sequencer.sv
design/vec_unit.sv
dv/tb_clk_gen.sv
dv/tb_vec_unit.sv

/* Bender.yml */
package:
  name: mini_vec

sources:
  - design/vec_pkg.sv
  - design/vec_dispatcher.sv
  - design/vec_insn_queue.sv
  - design/vec_lane.sv
  - design/vec_sequencer.sv
  - design/vec_unit.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_vec_unit.sv

/* dv/tb_vec_unit.sv */
// Testbench for the vec_unit coprocessor.
// Sends random instruction lists through the request channel, predicts each
// response with a register-file model and checks responses in order.
`timescale 1ns/100ps

module tb_vec_unit;

  import vec_pkg::*;

  localparam int unsigned NrLanes       = 4;
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned ResetCycles   = 10;
  localparam int unsigned TimeoutCycles = 500;

  logic    clk;
  logic    rst_n;
  vinstr_u req;
  logic    req_valid;
  logic    req_ready;
  elen_t   resp_result;
  logic    resp_error;
  logic    resp_valid;
  logic    resp_ready;

  integer      seed;
  logic [15:0] model_rf [8][NrLanes];
  logic [15:0] exp_result_q [$];
  logic        exp_error_q [$];
  logic [15:0] stim_q [$];
  string       cur_test;
  int          error_count;
  int          errors_before;
  int          pass_count;
  int          fail_count;

  tb_clk_gen #(.PeriodNs(8)) u_clk_gen (.clk_o(clk));

  vec_unit #(
    .NrLanes    (NrLanes   ),
    .QueueDepth (QueueDepth)
  ) u_vec_unit (
    .clk_i             (clk        ),
    .rst_n_i           (rst_n      ),
    .acc_req_i         (req        ),
    .acc_req_valid_i   (req_valid  ),
    .acc_req_ready_o   (req_ready  ),
    .acc_resp_result_o (resp_result),
    .acc_resp_error_o  (resp_error ),
    .acc_resp_valid_o  (resp_valid ),
    .acc_resp_ready_i  (resp_ready )
  );

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  function automatic logic [15:0] make_arith(input logic [2:0] op, input logic [2:0] vd,
                                             input logic [2:0] vs1, input logic [2:0] vs2);
    return {op, vd, vs1, vs2, 4'b0000};
  endfunction

  function automatic logic [15:0] make_imm(input logic [2:0] op, input logic [2:0] vd,
                                           input logic [9:0] imm);
    return {op, vd, imm};
  endfunction

  task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("ERROR %s: %s expected 0x%04h, actual 0x%04h", cur_test, what, exp, act);
      error_count++;
    end
  endtask

  // Reference model, applied in request order
  task automatic model_apply(input logic [15:0] w);
    logic [2:0]  op;
    logic [2:0]  vd;
    logic [2:0]  vs1;
    logic [2:0]  vs2;
    logic [15:0] imm;
    logic [15:0] res;
    op  = w[15:13];
    vd  = w[12:10];
    vs1 = w[9:7];
    vs2 = w[6:4];
    imm = {6'b0, w[9:0]};
    res = '0;
    for (int l = 0; l < NrLanes; l++) begin
      case (op)
        3'd0: model_rf[vd][l] = model_rf[vs1][l] + model_rf[vs2][l];
        3'd1: model_rf[vd][l] = model_rf[vs1][l] - model_rf[vs2][l];
        3'd2: model_rf[vd][l] = model_rf[vs1][l] & model_rf[vs2][l];
        3'd3: model_rf[vd][l] = imm;
        3'd4: res = res + model_rf[vs1][l];
        default: ;
      endcase
    end
    if (op == 3'd5) begin
      res = model_rf[vd][imm & (NrLanes - 1)];
    end
    exp_result_q.push_back(res);
    exp_error_q.push_back(op > 3'd5);
  endtask

  task automatic apply_reset();
    rst_n     = 1'b0;
    req_valid = 1'b0;
    for (int i = 0; i < ResetCycles; i++) begin
      @(posedge clk);
    end
    #1 rst_n = 1'b1;
    for (int r = 0; r < 8; r++) begin
      for (int l = 0; l < NrLanes; l++) begin
        model_rf[r][l] = '0;
      end
    end
  endtask

  // Leaves a response waiting with ready low, so reset has state to clear
  task automatic leave_response_pending();
    int waited;
    resp_ready = 1'b0;
    req        = make_imm(VSPLAT, 3'd1, 10'h2a5);
    req_valid  = 1'b1;
    waited     = 0;
    while (!resp_valid && waited <= TimeoutCycles) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (waited > TimeoutCycles) begin
      $display("Timeout: no response became valid before reset in test %s", cur_test);
      error_count++;
    end
    req_valid = 1'b0;
  endtask

  // Runs at 1 ns after a rising edge, keeps valid high between words
  task automatic send_list();
    int waited;
    for (int i = 0; i < stim_q.size(); i++) begin
      model_apply(stim_q[i]);
      req       = stim_q[i];
      req_valid = 1'b1;
      waited    = 0;
      while (!req_ready && waited <= TimeoutCycles) begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (waited > TimeoutCycles) begin
        $display("Timeout: request was never accepted in test %s", cur_test);
        error_count++;
        break;
      end
      @(posedge clk);
      #1;
    end
    req_valid = 1'b0;
  endtask

  task automatic collect_responses(input int n, input bit rand_ready);
    int          got;
    int          idle;
    logic        held;
    logic [15:0] held_result;
    logic        held_error;
    got  = 0;
    idle = 0;
    held = 1'b0;
    while (got < n) begin
      @(posedge clk);
      #1;
      resp_ready = rand_ready ? next_random() % 2 : 1'b1;
      if (held) begin
        assert (resp_valid && resp_result === held_result && resp_error === held_error)
        else begin
          $display("Response dropped or changed while valid was held in test %s", cur_test);
          error_count++;
        end
      end
      held        = resp_valid && !resp_ready;
      held_result = resp_result;
      held_error  = resp_error;
      idle++;
      if (resp_valid && resp_ready) begin
        if (exp_result_q.size() == 0) begin
          $display("Response arrived with no request outstanding in test %s", cur_test);
          error_count++;
        end else begin
          check_value("result", exp_result_q.pop_front(), resp_result);
          check_value("error", 16'(exp_error_q.pop_front()), 16'(resp_error));
        end
        got++;
        idle = 0;
      end
      if (idle > TimeoutCycles) begin
        $display("Timeout: a response never arrived in test %s", cur_test);
        error_count++;
        break;
      end
    end
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    errors_before = error_count;
  endtask

  task automatic run_stimulus(input bit rand_ready);
    int n;
    n = stim_q.size();
    fork
      send_list();
      collect_responses(n, rand_ready);
    join
    resp_ready = 1'b1;
    if (exp_result_q.size() != 0) begin
      $display("%0d responses missing in test %s", exp_result_q.size(), cur_test);
      error_count++;
    end
    exp_result_q.delete();
    exp_error_q.delete();
    stim_q.delete();
  endtask

  task automatic finish_test();
    if (error_count == errors_before) begin
      pass_count++;
      $display("Test %s: passed", cur_test);
    end else begin
      fail_count++;
      $display("Test %s: failed", cur_test);
    end
  endtask

  // Splat a random immediate into every register
  task automatic queue_splats();
    logic [31:0] rv;
    for (int r = 0; r < 8; r++) begin
      rv = next_random();
      stim_q.push_back(make_imm(VSPLAT, 3'(r), rv[9:0]));
    end
  endtask

  // Extract every lane of every register, random upper immediate bits
  task automatic queue_extracts();
    logic [31:0] rv;
    for (int r = 0; r < 8; r++) begin
      for (int l = 0; l < NrLanes; l++) begin
        rv = next_random();
        stim_q.push_back(make_imm(VEXT, 3'(r), {rv[7:0], 2'(l)}));
      end
    end
  endtask

  initial begin : main
    logic [31:0] rv;
    seed        = 32'h8905_623e;
    rst_n       = 1'b0;
    req         = '0;
    req_valid   = 1'b0;
    resp_ready  = 1'b1;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    apply_reset();

    start_test("splat_extract");
    queue_splats();
    queue_extracts();
    run_stimulus(1'b0);
    finish_test();

    start_test("elementwise");
    queue_splats();
    for (int i = 0; i < 12; i++) begin
      rv = next_random();
      stim_q.push_back(make_arith(3'(rv[17:16] % 3), rv[12:10], rv[9:7], rv[6:4]));
    end
    queue_extracts();
    run_stimulus(1'b0);
    finish_test();

    start_test("reduction");
    queue_splats();
    for (int r = 0; r < 8; r++) begin
      rv = next_random();
      stim_q.push_back(make_arith(VREDSUM, rv[2:0], 3'(r), rv[6:4]));
    end
    run_stimulus(1'b0);
    finish_test();

    start_test("illegal_opcode");
    for (int i = 0; i < 6; i++) begin
      rv = next_random();
      stim_q.push_back({2'b11, rv[13:0]});
    end
    queue_extracts();
    run_stimulus(1'b0);
    finish_test();

    start_test("backpressure");
    for (int i = 0; i < 40; i++) begin
      rv = next_random();
      stim_q.push_back({3'(rv[31:16] % 6), rv[12:0]});
    end
    run_stimulus(1'b1);
    finish_test();

    start_test("reset_state");
    leave_response_pending();
    apply_reset();
    resp_ready = 1'b1;
    check_value("resp_valid after reset", 16'd0, 16'(resp_valid));
    for (int r = 0; r < 8; r++) begin
      stim_q.push_back(make_arith(VREDSUM, 3'd0, 3'(r), 3'd0));
    end
    run_stimulus(1'b0);
    finish_test();

    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_vec_unit

/* dv/tb_clk_gen.sv */
// Free-running testbench clock.
// Instantiated once by the testbench top; the period is set in ns.
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

endmodule : tb_clk_gen

/* design/vec_unit.sv */
// Top level of the mini_vec coprocessor.
// Dispatcher feeds the instruction queue, which feeds the sequencer and its
// lanes; one response per request comes back in order.
`timescale 1ns/100ps

module vec_unit #(
  parameter int unsigned NrLanes    = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Request channel
  input  vec_pkg::vinstr_u acc_req_i,
  input  logic             acc_req_valid_i,
  output logic             acc_req_ready_o,
  // Response channel
  output vec_pkg::elen_t   acc_resp_result_o,
  output logic             acc_resp_error_o,
  output logic             acc_resp_valid_o,
  input  logic             acc_resp_ready_i
);

  import vec_pkg::*;

  // Dispatcher to queue
  vinsn_t insn;
  logic   insn_valid;
  logic   insn_ready;
  // Queue to sequencer
  vinsn_t head_insn;
  logic   head_valid;
  logic   head_pop;

  vec_dispatcher i_dispatcher (
    .clk_i           (clk_i          ),
    .rst_n_i         (rst_n_i        ),
    .acc_req_i       (acc_req_i      ),
    .acc_req_valid_i (acc_req_valid_i),
    .acc_req_ready_o (acc_req_ready_o),
    .insn_o          (insn           ),
    .insn_valid_o    (insn_valid     ),
    .insn_ready_i    (insn_ready     )
  );

  vec_insn_queue #(
    .QueueDepth(QueueDepth)
  ) i_insn_queue (
    .clk_i        (clk_i     ),
    .rst_n_i      (rst_n_i   ),
    .push_insn_i  (insn      ),
    .push_valid_i (insn_valid),
    .push_ready_o (insn_ready),
    .head_insn_o  (head_insn ),
    .head_valid_o (head_valid),
    .pop_i        (head_pop  )
  );

  vec_sequencer #(
    .NrLanes(NrLanes)
  ) i_sequencer (
    .clk_i             (clk_i            ),
    .rst_n_i           (rst_n_i          ),
    .head_insn_i       (head_insn        ),
    .head_valid_i      (head_valid       ),
    .pop_o             (head_pop         ),
    .acc_resp_result_o (acc_resp_result_o),
    .acc_resp_error_o  (acc_resp_error_o ),
    .acc_resp_valid_o  (acc_resp_valid_o ),
    .acc_resp_ready_i  (acc_resp_ready_i )
  );

endmodule : vec_unit

/* design/vec_sequencer.sv */
// Back end of the coprocessor.
// Pops decoded entries, broadcasts them to the lanes in the pop cycle,
// forms the scalar result and holds it in the response register until the
// core takes it.
`timescale 1ns/100ps

module vec_sequencer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Queue head
  input  vec_pkg::vinsn_t head_insn_i,
  input  logic            head_valid_i,
  output logic            pop_o,
  // Response channel to the core
  output vec_pkg::elen_t  acc_resp_result_o,
  output logic            acc_resp_error_o,
  output logic            acc_resp_valid_o,
  input  logic            acc_resp_ready_i
);

  import vec_pkg::*;

  if (NrLanes == 0 || NrLanes > MaxNrLanes) begin : gen_lane_check
    $error("vec_sequencer: NrLanes must be between 1 and MaxNrLanes");
  end

  elen_t [NrLanes-1:0] lane_vs1_data;
  elen_t [NrLanes-1:0] lane_vd_data;
  logic                lane_exec;
  elen_t               ext_idx;
  elen_t               redsum;
  elen_t               ext_data;
  elen_t               result_d;
  elen_t               resp_result_q;
  logic                resp_error_q;
  logic                resp_valid_q;

  // Pop only when the response slot is free or being freed
  assign pop_o     = head_valid_i && (!resp_valid_q || acc_resp_ready_i);
  assign lane_exec = pop_o && !head_insn_i.illegal;

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i      (clk_i            ),
      .rst_n_i    (rst_n_i          ),
      .exec_i     (lane_exec        ),
      .op_i       (head_insn_i.op   ),
      .vd_i       (head_insn_i.vd   ),
      .vs1_i      (head_insn_i.vs1  ),
      .vs2_i      (head_insn_i.vs2  ),
      .imm_i      (head_insn_i.imm  ),
      .vs1_data_o (lane_vs1_data[l] ),
      .vd_data_o  (lane_vd_data[l]  )
    );
  end : gen_lanes

  // Lane select for extract, low bits of the immediate
  assign ext_idx = head_insn_i.imm & elen_t'(NrLanes - 1);

  always_comb begin
    redsum   = '0;
    ext_data = '0;
    for (int l = 0; l < NrLanes; l++) begin
      redsum = redsum + lane_vs1_data[l];
      if (ext_idx == elen_t'(l)) begin
        ext_data = lane_vd_data[l];
      end
    end
  end

  // Element-wise and illegal ops return zero
  always_comb begin
    case (head_insn_i.op)
      VREDSUM: result_d = redsum;
      VEXT:    result_d = ext_data;
      default: result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (pop_o) begin
      resp_valid_q <= 1'b1;
    end else if (acc_resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Response payload, loaded in the pop cycle
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      resp_result_q <= result_d;
      resp_error_q  <= head_insn_i.illegal;
    end
  end

  assign acc_resp_result_o = resp_result_q;
  assign acc_resp_error_o  = resp_error_q;
  assign acc_resp_valid_o  = resp_valid_q;

endmodule : vec_sequencer

/* design/vec_lane.sv */
// One vector lane.
// Holds this lane's element of all eight vector registers and the element
// ALU; writes happen on the exec strobe, reads are combinational.
`timescale 1ns/100ps

module vec_lane (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Broadcast from the sequencer
  input  logic               exec_i,
  input  vec_pkg::vop_e      op_i,
  input  vec_pkg::vreg_idx_t vd_i,
  input  vec_pkg::vreg_idx_t vs1_i,
  input  vec_pkg::vreg_idx_t vs2_i,
  input  vec_pkg::elen_t     imm_i,
  // Operand reads for reduction and extract
  output vec_pkg::elen_t     vs1_data_o,
  output vec_pkg::elen_t     vd_data_o
);

  import vec_pkg::*;

  elen_t rf [8];
  elen_t op_a;
  elen_t op_b;

  assign op_a = rf[vs1_i];
  assign op_b = rf[vs2_i];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 8; i++) begin
        rf[i] <= '0;
      end
    end else if (exec_i) begin
      case (op_i)
        VADD:    rf[vd_i] <= op_a + op_b;
        VSUB:    rf[vd_i] <= op_a - op_b;
        VAND:    rf[vd_i] <= op_a & op_b;
        VSPLAT:  rf[vd_i] <= imm_i;
        // Reduction and extract only read
        default: ;
      endcase
    end
  end

  assign vs1_data_o = rf[vs1_i];
  assign vd_data_o  = rf[vd_i];

endmodule : vec_lane

/* design/vec_insn_queue.sv */
// Instruction queue between dispatcher and sequencer.
// Circular FIFO of decoded entries; push and pop may happen together.
`timescale 1ns/100ps

module vec_insn_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Push side
  input  vec_pkg::vinsn_t push_insn_i,
  input  logic            push_valid_i,
  output logic            push_ready_o,
  // Pop side
  output vec_pkg::vinsn_t head_insn_o,
  output logic            head_valid_o,
  input  logic            pop_i
);

  import vec_pkg::*;

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  vinsn_t            mem [QueueDepth];
  logic [PtrW-1:0]   wr_ptr;
  logic [PtrW-1:0]   rd_ptr;
  logic [CntW-1:0]   count;
  logic              do_push;
  logic              do_pop;

  assign push_ready_o = (count != CntW'(QueueDepth));
  assign head_valid_o = (count != '0);
  assign head_insn_o  = mem[rd_ptr];

  assign do_push = push_valid_i && push_ready_o;
  assign do_pop  = pop_i && head_valid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy stays put on a simultaneous push and pop
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_insn_i;
    end
  end

endmodule : vec_insn_queue

/* design/vec_dispatcher.sv */
// Front end of the coprocessor.
// Takes instruction words from the core, decodes them into queue entries
// and holds one entry until the instruction queue accepts it.
`timescale 1ns/100ps

module vec_dispatcher (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Request channel from the core
  input  vec_pkg::vinstr_u acc_req_i,
  input  logic             acc_req_valid_i,
  output logic             acc_req_ready_o,
  // Decoded entry towards the queue
  output vec_pkg::vinsn_t  insn_o,
  output logic             insn_valid_o,
  input  logic             insn_ready_i
);

  import vec_pkg::*;

  vinsn_t dec_insn;
  vinsn_t insn_q;
  logic   insn_valid_q;
  logic   req_accept;

  // Decode through the form the opcode selects
  always_comb begin
    dec_insn = '0;
    case (acc_req_i.arith.op)
      VADD, VSUB, VAND, VREDSUM: begin
        dec_insn.op  = acc_req_i.arith.op;
        dec_insn.vd  = acc_req_i.arith.vd;
        dec_insn.vs1 = acc_req_i.arith.vs1;
        dec_insn.vs2 = acc_req_i.arith.vs2;
      end
      VSPLAT, VEXT: begin
        dec_insn.op  = acc_req_i.immed.op;
        dec_insn.vd  = acc_req_i.immed.vd;
        // Zero-extended immediate
        dec_insn.imm = elen_t'(acc_req_i.immed.imm);
      end
      default: begin
        dec_insn.op      = acc_req_i.arith.op;
        dec_insn.illegal = 1'b1;
      end
    endcase
  end

  // Ready when the output register is empty or drains this cycle
  assign acc_req_ready_o = !insn_valid_q || insn_ready_i;
  assign req_accept      = acc_req_valid_i && acc_req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      insn_valid_q <= 1'b0;
    end else if (req_accept) begin
      insn_valid_q <= 1'b1;
    end else if (insn_ready_i) begin
      insn_valid_q <= 1'b0;
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      insn_q <= dec_insn;
    end
  end

  assign insn_o       = insn_q;
  assign insn_valid_o = insn_valid_q;

endmodule : vec_dispatcher

/* design/vec_pkg.sv */
// Shared types for the mini_vec coprocessor.
// Holds the opcode set, the two readings of the instruction word and the
// decoded entry that travels from the dispatcher through the queue.
package vec_pkg;

  // Upper bound on the number of lanes
  localparam int unsigned MaxNrLanes = 8;

  typedef logic [15:0] elen_t;
  typedef logic [2:0]  vreg_idx_t;

  // Opcodes 6 and 7 are left unassigned and decode as illegal
  typedef enum logic [2:0] {
    VADD    = 3'd0,
    VSUB    = 3'd1,
    VAND    = 3'd2,
    VSPLAT  = 3'd3,
    VREDSUM = 3'd4,
    VEXT    = 3'd5
  } vop_e;

  // Register-register form
  typedef struct packed {
    vop_e       op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    logic [3:0] unused;
  } vinstr_arith_t;

  // Immediate form, used by VSPLAT and VEXT
  typedef struct packed {
    vop_e       op;
    vreg_idx_t  vd;
    logic [9:0] imm;
  } vinstr_imm_t;

  // One 16-bit word, read according to its opcode
  typedef union packed {
    vinstr_arith_t arith;
    vinstr_imm_t   immed;
  } vinstr_u;

  // Decoded queue entry, 32 bits wide
  typedef struct packed {
    vop_e       op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    elen_t      imm;
    logic       illegal;
    logic [2:0] rsvd;
  } vinsn_t;

endpackage : vec_pkg
